// File: design/interconnect_pkg.sv
package interconnect_pkg;

  // ====================
  // message geometry
  // ====================

  localparam int ADDR_BITS = 4;
  localparam int DATA_BITS = 16;
  // endpoint address sits on top of the data word
  localparam int MSG_BITS = ADDR_BITS + DATA_BITS;

  // pass-through, classifier, loopback
  localparam int N_RESP_SRC = 3;

  typedef logic [MSG_BITS-1:0] msg_t;
  typedef logic [DATA_BITS-1:0] data_t;

  // ====================
  // encodings
  // ====================

  // endpoint opcodes, anything else is unmapped
  typedef enum logic [ADDR_BITS-1:0] {
    ADDR_XBAR_DATA  = 4'd0,
    ADDR_XBAR_CFG   = 4'd1,
    ADDR_CUTOFF_CFG = 4'd2,
    ADDR_LOOPBACK   = 4'd9
  } addr_e;

  // arbiter input index, also the response tag
  typedef enum logic [ADDR_BITS-1:0] {
    SRC_PASS  = 4'd0,
    SRC_CLASS = 4'd1,
    SRC_LOOP  = 4'd2
  } resp_src_e;

  // crossbar output select
  typedef enum logic {
    ROUTE_PASS  = 1'b0,
    ROUTE_CLASS = 1'b1
  } route_e;

endpackage

// File: design/route_ctrl.sv
`timescale 1ns/1ps

module route_ctrl (
  input  logic                     clk,
  input  logic                     rst_n_i,
  // host stream
  input  logic                     host_val_i,
  input  interconnect_pkg::msg_t   host_msg_i,
  output logic                     host_rdy_o,
  // sample stream into the crossbar
  output logic                     xbar_val_o,
  output interconnect_pkg::data_t  xbar_data_o,
  input  logic                     xbar_rdy_i,
  // loopback stream into the arbiter
  output logic                     loop_val_o,
  output interconnect_pkg::data_t  loop_data_o,
  input  logic                     loop_rdy_i,
  // configuration registers
  output interconnect_pkg::route_e route_o,
  output interconnect_pkg::data_t  cutoff_o
);
  import interconnect_pkg::*;

  addr_e  host_addr;
  data_t  host_data;
  logic   host_fire;
  route_e route_q;
  data_t  cutoff_q;

  // split the message into opcode and payload
  assign host_addr = addr_e'(host_msg_i[MSG_BITS-1 -: ADDR_BITS]);
  assign host_data = host_msg_i[DATA_BITS-1:0];

  // ====================
  // handshake steering
  // ====================

  // both data outputs just follow the payload, valid picks the endpoint
  assign xbar_data_o = host_data;
  assign loop_data_o = host_data;

  always_comb begin
    xbar_val_o = 1'b0;
    loop_val_o = 1'b0;
    // config and unmapped addresses never stall
    host_rdy_o = 1'b1;
    case (host_addr)
      ADDR_XBAR_DATA: begin
        xbar_val_o = host_val_i;
        host_rdy_o = xbar_rdy_i;
      end
      ADDR_LOOPBACK: begin
        loop_val_o = host_val_i;
        host_rdy_o = loop_rdy_i;
      end
      default: begin
        // config writes land in the registers below
        // unmapped messages are swallowed here
        xbar_val_o = 1'b0;
        loop_val_o = 1'b0;
      end
    endcase
  end

  assign host_fire = host_val_i && host_rdy_o;

  // ====================
  // config registers
  // ====================

  // new value is visible to the very next message
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      route_q  <= ROUTE_PASS;
      cutoff_q <= '0;
    end else if (host_fire) begin
      case (host_addr)
        ADDR_XBAR_CFG: begin
          // only the lsb selects the route
          route_q <= route_e'(host_data[0]);
        end
        ADDR_CUTOFF_CFG: begin
          cutoff_q <= host_data;
        end
        default: begin
          route_q  <= route_q;
          cutoff_q <= cutoff_q;
        end
      endcase
    end
  end

  assign route_o  = route_q;
  assign cutoff_o = cutoff_q;

endmodule

// File: design/stream_xbar.sv
`timescale 1ns/1ps

module stream_xbar (
  input  interconnect_pkg::route_e route_i,
  // input stream
  input  logic                     in_val_i,
  input  interconnect_pkg::data_t  in_data_i,
  output logic                     in_rdy_o,
  // output 0, straight to the response path
  output logic                     pass_val_o,
  output interconnect_pkg::data_t  pass_data_o,
  input  logic                     pass_rdy_i,
  // output 1, into the classifier
  output logic                     class_val_o,
  output interconnect_pkg::data_t  class_data_o,
  input  logic                     class_rdy_i
);
  import interconnect_pkg::*;

  logic sel_class;

  assign sel_class = (route_i == ROUTE_CLASS);

  // ====================
  // forward path
  // ====================

  // data fans out to both, the unselected side never sees valid
  assign pass_data_o  = in_data_i;
  assign class_data_o = in_data_i;

  assign pass_val_o  = in_val_i && !sel_class;
  assign class_val_o = in_val_i && sel_class;

  // ====================
  // backward path
  // ====================

  // ready comes from whichever output is selected
  assign in_rdy_o = sel_class ? class_rdy_i : pass_rdy_i;

endmodule

// File: design/mag_classifier.sv
`timescale 1ns/1ps

module mag_classifier (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // sample stream
  input  logic                    in_val_i,
  input  interconnect_pkg::data_t in_data_i,
  output logic                    in_rdy_o,
  // unsigned cutoff magnitude
  input  interconnect_pkg::data_t cutoff_i,
  // one-bit result stream
  output logic                    out_val_o,
  output logic                    out_bit_o,
  input  logic                    out_rdy_i
);
  import interconnect_pkg::*;

  // one extra bit so the most negative sample gives 32768
  logic [DATA_BITS:0] mag;
  logic               above;
  logic               in_fire;
  logic               full_q;
  logic               bit_q;

  // two's complement absolute value
  assign mag = in_data_i[DATA_BITS-1] ? ({1'b0, ~in_data_i} + 1'b1) : {1'b0, in_data_i};

  // strictly greater than the cutoff
  assign above = (mag > {1'b0, cutoff_i});

  // one-entry output buffer, can refill while draining
  assign in_rdy_o = !full_q || out_rdy_i;
  assign in_fire  = in_val_i && in_rdy_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (in_fire) begin
      full_q <= 1'b1;
    end else if (out_rdy_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      bit_q <= above;
    end
  end

  assign out_val_o = full_q;
  assign out_bit_o = bit_q;

endmodule

// File: design/resp_arbiter.sv
`timescale 1ns/1ps

module resp_arbiter (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // source 0, crossbar pass-through
  input  logic                    pass_val_i,
  input  interconnect_pkg::data_t pass_data_i,
  output logic                    pass_rdy_o,
  // source 1, classifier result
  input  logic                    class_val_i,
  input  logic                    class_bit_i,
  output logic                    class_rdy_o,
  // source 2, loopback
  input  logic                    loop_val_i,
  input  interconnect_pkg::data_t loop_data_i,
  output logic                    loop_rdy_o,
  // tagged response to the host
  output logic                    resp_val_o,
  output interconnect_pkg::msg_t  resp_msg_o,
  input  logic                    resp_rdy_i
);
  import interconnect_pkg::*;

  logic [N_RESP_SRC-1:0] req;
  logic                  grant_vld;
  resp_src_e             grant_src;
  data_t                 grant_data;
  logic                  buf_free;
  logic                  win;
  resp_src_e             last_q;
  logic                  full_q;
  msg_t                  msg_q;

  // request vector indexed by source tag
  assign req = {loop_val_i, class_val_i, pass_val_i};

  // ====================
  // round-robin grant
  // ====================

  // search starts one past the last winner
  always_comb begin : grant_search
    int idx;
    grant_vld = 1'b0;
    grant_src = last_q;
    for (int k = 1; k <= N_RESP_SRC; k++) begin
      idx = (int'(last_q) + k) % N_RESP_SRC;
      if (!grant_vld && req[idx]) begin
        grant_vld = 1'b1;
        grant_src = resp_src_e'(idx[ADDR_BITS-1:0]);
      end
    end
  end

  always_comb begin
    case (grant_src)
      SRC_PASS:  grant_data = pass_data_i;
      // classifier bit is zero-extended
      SRC_CLASS: grant_data = {{(DATA_BITS-1){1'b0}}, class_bit_i};
      SRC_LOOP:  grant_data = loop_data_i;
      default:   grant_data = '0;
    endcase
  end

  // buffer takes a new entry while empty or draining
  assign buf_free = !full_q || resp_rdy_i;
  assign win      = grant_vld && buf_free;

  assign pass_rdy_o  = buf_free && grant_vld && (grant_src == SRC_PASS);
  assign class_rdy_o = buf_free && grant_vld && (grant_src == SRC_CLASS);
  assign loop_rdy_o  = buf_free && grant_vld && (grant_src == SRC_LOOP);

  // pointer starts at loop so pass-through wins first
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      last_q <= SRC_LOOP;
    end else if (win) begin
      full_q <= 1'b1;
      last_q <= grant_src;
    end else if (resp_rdy_i) begin
      full_q <= 1'b0;
    end
  end

  // tag goes in the address field
  always_ff @(posedge clk) begin
    if (win) begin
      msg_q <= {grant_src, grant_data};
    end
  end

  assign resp_val_o = full_q;
  assign resp_msg_o = msg_q;

endmodule

// File: design/interconnect_top.sv
`timescale 1ns/1ps

module interconnect_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  // host request stream
  input  logic                   host_val_i,
  input  interconnect_pkg::msg_t host_msg_i,
  output logic                   host_rdy_o,
  // tagged response stream
  output logic                   resp_val_o,
  output interconnect_pkg::msg_t resp_msg_o,
  input  logic                   resp_rdy_i
);
  import interconnect_pkg::*;

  logic   xbar_val;
  data_t  xbar_data;
  logic   xbar_rdy;
  logic   loop_val;
  data_t  loop_data;
  logic   loop_rdy;
  route_e route;
  data_t  cutoff;
  logic   pass_val;
  data_t  pass_data;
  logic   pass_rdy;
  logic   class_in_val;
  data_t  class_in_data;
  logic   class_in_rdy;
  logic   class_val;
  logic   class_bit;
  logic   class_rdy;

  // ====================
  // request side
  // ====================

  route_ctrl u_route_ctrl (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .host_val_i  (host_val_i),
    .host_msg_i  (host_msg_i),
    .host_rdy_o  (host_rdy_o),
    .xbar_val_o  (xbar_val),
    .xbar_data_o (xbar_data),
    .xbar_rdy_i  (xbar_rdy),
    .loop_val_o  (loop_val),
    .loop_data_o (loop_data),
    .loop_rdy_i  (loop_rdy),
    .route_o     (route),
    .cutoff_o    (cutoff)
  );

  stream_xbar u_stream_xbar (
    .route_i      (route),
    .in_val_i     (xbar_val),
    .in_data_i    (xbar_data),
    .in_rdy_o     (xbar_rdy),
    .pass_val_o   (pass_val),
    .pass_data_o  (pass_data),
    .pass_rdy_i   (pass_rdy),
    .class_val_o  (class_in_val),
    .class_data_o (class_in_data),
    .class_rdy_i  (class_in_rdy)
  );

  mag_classifier u_mag_classifier (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .in_val_i  (class_in_val),
    .in_data_i (class_in_data),
    .in_rdy_o  (class_in_rdy),
    .cutoff_i  (cutoff),
    .out_val_o (class_val),
    .out_bit_o (class_bit),
    .out_rdy_i (class_rdy)
  );

  // ====================
  // response side
  // ====================

  resp_arbiter u_resp_arbiter (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pass_val_i  (pass_val),
    .pass_data_i (pass_data),
    .pass_rdy_o  (pass_rdy),
    .class_val_i (class_val),
    .class_bit_i (class_bit),
    .class_rdy_o (class_rdy),
    .loop_val_i  (loop_val),
    .loop_data_i (loop_data),
    .loop_rdy_o  (loop_rdy),
    .resp_val_o  (resp_val_o),
    .resp_msg_o  (resp_msg_o),
    .resp_rdy_i  (resp_rdy_i)
  );

endmodule

// File: verification/tb_interconnect.sv
`timescale 1ns/1ps

module tb_interconnect;
  import interconnect_pkg::*;

  localparam int CLK_HALF     = 2;
  localparam int WAIT_LIMIT   = 200;
  localparam int QUIET_CYCLES = 3;

  logic        clk;
  logic        rst_n_i;
  logic        host_val_i;
  msg_t        host_msg_i;
  logic        host_rdy_o;
  logic        resp_val_o;
  msg_t        resp_msg_o;
  logic        resp_rdy_i;

  logic [31:0] lfsr_q;
  int          resp_seen = 0;
  int          resp_expected;
  int          tests_run;
  int          tests_failed;
  int          errors;

  interconnect_top dut (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .host_val_i (host_val_i),
    .host_msg_i (host_msg_i),
    .host_rdy_o (host_rdy_o),
    .resp_val_o (resp_val_o),
    .resp_msg_o (resp_msg_o),
    .resp_rdy_i (resp_rdy_i)
  );

  always #CLK_HALF clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1, new bit enters at the lsb
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // every response handshake, the transfer lands on the next rising edge
  always @(negedge clk) begin
    if (rst_n_i && resp_val_o && resp_rdy_i) begin
      resp_seen = resp_seen + 1;
    end
  end

  // ====================
  // handshake tasks
  // ====================

  // called on a rising edge, returns on the edge of the transfer
  task automatic send_msg(input msg_t msg, output logic ok);
    int waited;
    ok = 1'b0;
    waited = 0;
    host_val_i <= 1'b1;
    host_msg_i <= msg;
    resp_rdy_i <= 1'b1;
    while (!ok && waited < WAIT_LIMIT) begin
      @(negedge clk);
      if (host_rdy_o) begin
        ok = 1'b1;
      end
      @(posedge clk);
      waited++;
    end
    host_val_i <= 1'b0;
  endtask

  // random ready while waiting gives back-pressure on the buffer
  task automatic recv_resp(output msg_t msg, output logic ok);
    int waited;
    ok = 1'b0;
    waited = 0;
    msg = '0;
    while (!ok && waited < WAIT_LIMIT) begin
      lfsr_q = lfsr_next(lfsr_q);
      resp_rdy_i <= lfsr_q[0];
      @(negedge clk);
      if (resp_val_o && resp_rdy_i) begin
        ok = 1'b1;
        msg = resp_msg_o;
      end
      @(posedge clk);
      waited++;
    end
    resp_rdy_i <= 1'b1;
  endtask

  task automatic check_quiet(output logic ok);
    ok = 1'b1;
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (resp_val_o) begin
        ok = 1'b0;
      end
      @(posedge clk);
    end
  endtask

  task automatic run_test(input logic [8*24-1:0] name, input logic [3:0] addr,
                          input logic [15:0] data, input int want,
                          input msg_t exp_msg, output logic abort_o);
    msg_t got;
    logic ok;
    abort_o = 1'b0;
    tests_run++;
    send_msg({addr, data}, ok);
    if (!ok) begin
      $display("test %0s: host message was not accepted within %0d cycles", name, WAIT_LIMIT);
      tests_failed++;
      abort_o = 1'b1;
    end else if (want != 0) begin
      resp_expected++;
      recv_resp(got, ok);
      if (!ok) begin
        $display("test %0s: no response arrived within %0d cycles", name, WAIT_LIMIT);
        tests_failed++;
        abort_o = 1'b1;
      end else if (got !== exp_msg) begin
        $display("MISMATCH %0s expected %h actual %h", name, exp_msg, got);
        tests_failed++;
      end else begin
        $display("ok %0s response %h", name, got);
      end
    end else begin
      check_quiet(ok);
      if (!ok) begin
        $display("test %0s: a response came back for a message that has none", name);
        tests_failed++;
      end else begin
        $display("ok %0s no response", name);
      end
    end
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin : main
    int                fd;
    int                n;
    string             line;
    logic [8*24-1:0]   name;
    logic [3:0]        addr;
    logic [15:0]       data;
    int                want;
    logic [19:0]       exp_msg;
    logic              abort;
    clk = 1'b0;
    rst_n_i = 1'b0;
    host_val_i = 1'b0;
    host_msg_i = '0;
    resp_rdy_i = 1'b1;
    lfsr_q = 32'h4f8e_0c21;
    resp_expected = 0;
    tests_run = 0;
    tests_failed = 0;
    errors = 0;
    abort = 1'b0;
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);

    fd = $fopen("verification/interconnect_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file verification/interconnect_tests.txt");
      errors++;
      abort = 1'b1;
    end
    while (!abort && !$feof(fd)) begin
      n = $fgets(line, fd);
      // skip blank lines and the column notes
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %d %h", name, addr, data, want, exp_msg);
        if (n != 5) begin
          $display("malformed line in the test file: %0s", line);
          errors++;
        end else begin
          run_test(name, addr, data, want, exp_msg, abort);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    // let any stray response show up before counting
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(posedge clk);
    end
    if (resp_seen != resp_expected) begin
      $display("response count is wrong: %0d expected, %0d seen", resp_expected, resp_seen);
      errors++;
    end

    $display("tests run %0d, failed %0d, other errors %0d, responses %0d", tests_run,
             tests_failed, errors, resp_seen);
    if (tests_failed == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verification/interconnect_tests.txt
# name  addr(hex)  data(hex)  response expected (0/1)  expected response (hex, tag then data)
# tags: 0 pass-through, 1 classifier, 2 loopback
loop_a                9 1234 1 21234
loop_b                9 ffff 1 2ffff
pass_default          0 0abc 1 00abc
pass_negative         0 8001 1 08001
cutoff_256            2 0100 0 00000
route_class           1 0001 0 00000
class_above           0 0101 1 10001
class_equal           0 0100 1 10000
class_below           0 00ff 1 10000
class_neg_above       0 feff 1 10001
class_neg_equal       0 ff00 1 10000
class_most_neg        0 8000 1 10001
unmapped_5            5 dead 0 00000
loop_after_unmapped   9 5a5a 1 25a5a
cutoff_max            2 7fff 0 00000
class_max_pos         0 7fff 1 10000
class_most_neg_max    0 8000 1 10001
route_pass_even       1 0002 0 00000
unmapped_15           f 0001 0 00000
pass_after_route      0 4321 1 04321
loop_last             9 0000 1 20000

// File: vlog.f
design/interconnect_pkg.sv
design/route_ctrl.sv
design/stream_xbar.sv
design/mag_classifier.sv
design/resp_arbiter.sv
design/interconnect_top.sv
verification/tb_interconnect.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_interconnect
FILELIST = vlog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

obj_dir/V%: $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $* -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TESTBENCH PASSED$$'

clean:
	rm -rf obj_dir
